// File: files.f
+incdir+include
hdl/chipset_pkg.sv
hdl/port_decoder.sv
hdl/ems_mapper.sv
hdl/bus_readback.sv
hdl/timer_prescaler.sv
hdl/chipset_top.sv
tb/tb_clock_gen.sv
tb/tb_chipset.sv

// File: hdl/bus_readback.sv
`timescale 1ns/10ps
`default_nettype none

`include "chipset_params.svh"

module bus_readback (
	input wire logic clock,
	input wire logic reset,
	input wire chipset_pkg::bus_byte_t data_i,
	input wire chipset_pkg::bus_byte_t ems_data_i,
	input wire logic ems_select_i,
	input wire logic lpt_select_i,
	input wire logic xtctl_select_i,
	input wire logic io_read_i,
	input wire logic io_write_n_i,
	output chipset_pkg::bus_byte_t data_o,
	output logic data_valid_o,
	output chipset_pkg::bus_byte_t xtctl_o
);

	chipset_pkg::bus_byte_t lpt_q;
	chipset_pkg::bus_byte_t xtctl_q;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lpt_q <= `LPT_RESET_VALUE;
			xtctl_q <= `XTCTL_RESET_VALUE;
		end else begin
			if (lpt_select_i && !io_write_n_i)
				lpt_q <= data_i;
			if (xtctl_select_i && !io_write_n_i)
				xtctl_q <= data_i;
		end
	end

	assign xtctl_o = xtctl_q;

	// ems first, then lpt, then xt control
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_o <= '0;
			data_valid_o <= 1'b0;
		end else if (io_read_i && ems_select_i) begin
			data_o <= ems_data_i;
			data_valid_o <= 1'b1;
		end else if (io_read_i && lpt_select_i) begin
			data_o <= lpt_q;
			data_valid_o <= 1'b1;
		end else if (io_read_i && xtctl_select_i) begin
			data_o <= xtctl_q;
			data_valid_o <= 1'b1;
		end else begin
			data_o <= '0;
			data_valid_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/chipset_pkg.sv
`default_nettype none

package chipset_pkg;

	// cpu side address, 1 MB space
	typedef logic [19:0] cpu_addr_t;

	typedef logic [7:0] bus_byte_t;

	// bit 20 set means the access went through an EMS page
	typedef logic [20:0] sram_addr_t;

	// 64 pages of 16 KB in the upper SRAM half
	typedef logic [5:0] ems_page_t;

	typedef logic [1:0] ems_index_t;

endpackage

`default_nettype wire

// File: hdl/chipset_top.sv
`timescale 1ns/10ps
`default_nettype none

module chipset_top (
	input wire logic clock,
	input wire logic reset,
	input wire chipset_pkg::cpu_addr_t address_i,
	input wire chipset_pkg::bus_byte_t data_i,
	input wire logic io_read_n_i,
	input wire logic io_write_n_i,
	input wire logic memory_read_n_i,
	input wire logic address_enable_n_i,
	input wire logic ems_enabled_i,
	input wire logic [1:0] ems_window_i,
	input wire logic peripheral_clock_i,
	output chipset_pkg::bus_byte_t data_o,
	output logic data_valid_o,
	output chipset_pkg::sram_addr_t sram_addr_o,
	output chipset_pkg::bus_byte_t xtctl_o,
	output logic timer_clock_o
);

	logic ems_select;
	logic ems_write;
	logic lpt_select;
	logic xtctl_select;
	logic io_read;
	chipset_pkg::bus_byte_t ems_data;

	port_decoder port_decoder0 (
		.address_i(address_i[15:0]),
		.io_read_n_i(io_read_n_i),
		.io_write_n_i(io_write_n_i),
		.address_enable_n_i(address_enable_n_i),
		.ems_enabled_i(ems_enabled_i),
		.ems_select_o(ems_select),
		.ems_write_o(ems_write),
		.lpt_select_o(lpt_select),
		.xtctl_select_o(xtctl_select),
		.io_read_o(io_read)
	);

	ems_mapper ems_mapper0 (
		.clock(clock),
		.reset(reset),
		.address_i(address_i),
		.data_i(data_i),
		.io_read_n_i(io_read_n_i),
		.io_write_n_i(io_write_n_i),
		.ems_window_i(ems_window_i),
		.ems_write_i(ems_write),
		.ems_data_o(ems_data),
		.sram_addr_o(sram_addr_o)
	);

	bus_readback bus_readback0 (
		.clock(clock),
		.reset(reset),
		.data_i(data_i),
		.ems_data_i(ems_data),
		.ems_select_i(ems_select),
		.lpt_select_i(lpt_select),
		.xtctl_select_i(xtctl_select),
		.io_read_i(io_read),
		.io_write_n_i(io_write_n_i),
		.data_o(data_o),
		.data_valid_o(data_valid_o),
		.xtctl_o(xtctl_o)
	);

	timer_prescaler timer_prescaler0 (
		.clock(clock),
		.reset(reset),
		.peripheral_clock_i(peripheral_clock_i),
		.timer_clock_o(timer_clock_o)
	);

	// a bus cycle is either memory or I/O, the mapper relies on it
	assert property (@(posedge clock) disable iff (reset)
		!(!address_enable_n_i && !memory_read_n_i && (!io_read_n_i || !io_write_n_i)))
		else $error("memory read during an I/O strobe");

endmodule

`default_nettype wire

// File: hdl/ems_mapper.sv
`timescale 1ns/10ps
`default_nettype none

`include "chipset_params.svh"

module ems_mapper (
	input wire logic clock,
	input wire logic reset,
	input wire chipset_pkg::cpu_addr_t address_i,
	input wire chipset_pkg::bus_byte_t data_i,
	input wire logic io_read_n_i,
	input wire logic io_write_n_i,
	input wire logic [1:0] ems_window_i,
	input wire logic ems_write_i,
	output chipset_pkg::bus_byte_t ems_data_o,
	output chipset_pkg::sram_addr_t sram_addr_o
);

	chipset_pkg::ems_page_t page_q [`EMS_PAGE_COUNT];
	logic [`EMS_PAGE_COUNT-1:0] enable_q;

	logic pend_valid;
	chipset_pkg::ems_index_t pend_index;
	chipset_pkg::ems_page_t pend_page;
	logic pend_enable;

	chipset_pkg::ems_index_t reg_index;
	chipset_pkg::ems_index_t slot;
	logic [3:0] frame;
	logic io_active;

	assign reg_index = address_i[1:0];

	// data 80..FE is ignored, so only FF and below 80 raise a pending write
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pend_valid <= 1'b0;
		end else begin
			pend_valid <= ems_write_i && (data_i == 8'hFF || data_i < 8'h80);
		end
	end

	always_ff @(posedge clock) begin
		pend_index <= reg_index;
		pend_enable <= (data_i != 8'hFF);
		pend_page <= (data_i == 8'hFF) ? 6'h3F : data_i[5:0];
	end

	// commit one edge after capture
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `EMS_PAGE_COUNT; i++) begin
				page_q[i] <= '0;
			end
			enable_q <= '0;
		end else if (pend_valid) begin
			page_q[pend_index] <= pend_page;
			enable_q[pend_index] <= pend_enable;
		end
	end

	// disabled pages read back as FF
	assign ems_data_o = enable_q[reg_index] ? {2'b00, page_q[reg_index]} : 8'hFF;

	assign io_active = !io_read_n_i || !io_write_n_i;
	assign slot = address_i[15:14];

	always_comb begin
		case (ems_window_i)
			2'd0: frame = `EMS_FRAME_A;
			2'd1: frame = `EMS_FRAME_C;
			default: frame = `EMS_FRAME_D;
		endcase
	end

	always_comb begin
		if (!io_active && address_i[19:16] == frame && enable_q[slot]) begin
			sram_addr_o = {1'b1, page_q[slot], address_i[`EMS_WINDOW_BITS-1:0]};
		end else begin
			sram_addr_o = {1'b0, address_i};
		end
	end

	// decoded EMS write must come with the bus write strobe
	assert property (@(posedge clock) disable iff (reset) pend_valid |-> $past(!io_write_n_i))
		else $error("EMS pending write without an I/O write strobe");

endmodule

`default_nettype wire

// File: hdl/port_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "chipset_params.svh"

module port_decoder (
	input wire logic [15:0] address_i,
	input wire logic io_read_n_i,
	input wire logic io_write_n_i,
	input wire logic address_enable_n_i,
	input wire logic ems_enabled_i,
	output logic ems_select_o,
	output logic ems_write_o,
	output logic lpt_select_o,
	output logic xtctl_select_o,
	output logic io_read_o
);

	logic io_cycle;

	assign io_cycle = !address_enable_n_i && (!io_read_n_i || !io_write_n_i);

	// four page registers on consecutive ports
	assign ems_select_o = io_cycle && ems_enabled_i &&
		({address_i[15:2], 2'b00} == `EMS_PORT_BASE);
	assign ems_write_o = ems_select_o && !io_write_n_i;

	assign lpt_select_o = io_cycle && (address_i == `LPT_PORT);
	assign xtctl_select_o = io_cycle && (address_i == `XTCTL_PORT);

	assign io_read_o = !io_read_n_i;

	// port map must not overlap
	always_comb begin
		assert ($onehot0({ems_select_o, lpt_select_o, xtctl_select_o}))
			else $error("overlapping port selects");
	end

endmodule

`default_nettype wire

// File: hdl/timer_prescaler.sv
`timescale 1ns/10ps
`default_nettype none

module timer_prescaler (
	input wire logic clock,
	input wire logic reset,
	input wire logic peripheral_clock_i,
	output logic timer_clock_o
);

	logic sync1_q;
	logic sync2_q;
	logic rise;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			sync1_q <= 1'b0;
			sync2_q <= 1'b0;
		end else begin
			sync1_q <= peripheral_clock_i;
			sync2_q <= sync1_q;
		end
	end

	assign rise = sync1_q && !sync2_q;

	// divide by two
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			timer_clock_o <= 1'b0;
		end else if (rise) begin
			timer_clock_o <= !timer_clock_o;
		end
	end

	// each peripheral clock level must span two clocks
	assert property (@(posedge clock) disable iff (reset)
		(sync1_q != sync2_q) |=> (sync1_q == sync2_q))
		else $error("peripheral clock level shorter than two clocks");

endmodule

`default_nettype wire

// File: include/chipset_params.svh
`ifndef CHIPSET_PARAMS_SVH
`define CHIPSET_PARAMS_SVH

// I/O port map
`define EMS_PORT_BASE 16'h0260
`define LPT_PORT 16'h0378
`define XTCTL_PORT 16'h8888

// address nibble of the EMS frame, one per window choice
`define EMS_FRAME_A 4'hA
`define EMS_FRAME_C 4'hC
`define EMS_FRAME_D 4'hD

// four 16 KB pages inside the frame
`define EMS_PAGE_COUNT 4
`define EMS_WINDOW_BITS 14

// register values after reset
`define LPT_RESET_VALUE 8'hFF
`define XTCTL_RESET_VALUE 8'h00

`endif

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_chipset -o sim_chipset

# the simulator status is masked by tee, the log search decides
./obj_dir/sim_chipset | tee sim.log
grep -q "Verification passed" sim.log

// File: tb/tb_chipset.sv
`timescale 1ns/10ps
`default_nettype none

`include "chipset_params.svh"

module tb_chipset;

	localparam int RESET_ACCESSES = 16;
	localparam int EMS_WRITES = 120;
	localparam int TRANSLATIONS = 40;
	localparam int PORT_ROUNDS = 8;
	localparam int DISABLED_WRITES = 16;
	localparam int NUM_TRANSACTIONS = RESET_ACCESSES + 2 * EMS_WRITES +
		4 * (`EMS_PAGE_COUNT + TRANSLATIONS) + 5 * PORT_ROUNDS + 2 * DISABLED_WRITES + 4;
	// strobe cycle plus idle cycle
	localparam int CYCLES_PER_TRANSACTION = 2;
	localparam int TIMEOUT_NS = (NUM_TRANSACTIONS * CYCLES_PER_TRANSACTION + 300) * 8;

	logic clock;
	logic reset;
	chipset_pkg::cpu_addr_t address;
	chipset_pkg::bus_byte_t data_in;
	logic io_read_n;
	logic io_write_n;
	logic memory_read_n;
	logic address_enable_n;
	logic ems_enabled;
	logic [1:0] ems_window;
	logic peripheral_clock;
	chipset_pkg::bus_byte_t data_out;
	logic data_valid;
	chipset_pkg::sram_addr_t sram_addr;
	chipset_pkg::bus_byte_t xtctl;
	logic timer_clock;

	// reference model state
	chipset_pkg::ems_page_t model_page [`EMS_PAGE_COUNT];
	logic [`EMS_PAGE_COUNT-1:0] model_en;
	chipset_pkg::bus_byte_t model_lpt;
	chipset_pkg::bus_byte_t model_xtctl;
	int rises = 0;
	int toggles = 0;
	int error_count = 0;
	logic timer_prev = 1'b0;
	logic peripheral_running;

	tb_clock_gen clock_gen0 (
		.clock_o(clock),
		.reset_o(reset)
	);

	chipset_top dut0 (
		.clock(clock),
		.reset(reset),
		.address_i(address),
		.data_i(data_in),
		.io_read_n_i(io_read_n),
		.io_write_n_i(io_write_n),
		.memory_read_n_i(memory_read_n),
		.address_enable_n_i(address_enable_n),
		.ems_enabled_i(ems_enabled),
		.ems_window_i(ems_window),
		.peripheral_clock_i(peripheral_clock),
		.data_o(data_out),
		.data_valid_o(data_valid),
		.sram_addr_o(sram_addr),
		.xtctl_o(xtctl),
		.timer_clock_o(timer_clock)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("Error: time %0t, %s, actual %0h, expected %0h", $time, name, actual,
				expected);
			$display("Verification failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	function automatic logic [3:0] frame_nibble(input logic [1:0] window);
		if (window == 2'd0)
			return `EMS_FRAME_A;
		else if (window == 2'd1)
			return `EMS_FRAME_C;
		return `EMS_FRAME_D;
	endfunction

	function automatic chipset_pkg::sram_addr_t expected_sram(input logic [19:0] addr,
		input logic [1:0] window);
		logic [1:0] j;
		j = addr[15:14];
		if (addr[19:16] == frame_nibble(window) && model_en[j])
			return {1'b1, model_page[j], addr[13:0]};
		return {1'b0, addr};
	endfunction

	function automatic void model_write(input logic [1:0] idx, input logic [7:0] value);
		if (value == 8'hFF) begin
			model_en[idx] = 1'b0;
			model_page[idx] = 6'h3F;
		end else if (value < 8'h80) begin
			model_en[idx] = 1'b1;
			model_page[idx] = value[5:0];
		end
	endfunction

	function automatic logic [7:0] ems_expected(input logic [1:0] idx);
		return model_en[idx] ? {2'b00, model_page[idx]} : 8'hFF;
	endfunction

	function automatic logic [15:0] ems_port(input logic [1:0] idx);
		return `EMS_PORT_BASE | {14'h0, idx};
	endfunction

	// FF, below 80, or the ignored 80..FE range
	function automatic logic [7:0] random_ems_data();
		logic [31:0] kind;
		logic [31:0] r;
		kind = $urandom_range(2, 0);
		r = $urandom();
		if (kind == 0)
			return 8'hFF;
		else if (kind == 1)
			return {1'b0, r[6:0]};
		return (r[6:0] == 7'h7F) ? 8'hFE : {1'b1, r[6:0]};
	endfunction

	task automatic io_write(input logic [15:0] port, input logic [7:0] value);
		@(posedge clock);
		address <= {4'h0, port};
		data_in <= value;
		address_enable_n <= 1'b0;
		io_write_n <= 1'b0;
		@(posedge clock);
		address_enable_n <= 1'b1;
		io_write_n <= 1'b1;
	endtask

	task automatic io_read(input logic [15:0] port, output logic [7:0] value,
		output logic valid);
		@(posedge clock);
		address <= {4'h0, port};
		address_enable_n <= 1'b0;
		io_read_n <= 1'b0;
		@(posedge clock);
		address_enable_n <= 1'b1;
		io_read_n <= 1'b1;
		@(negedge clock);
		value = data_out;
		valid = data_valid;
	endtask

	task automatic read_and_check(input logic [15:0] port, input logic [7:0] expected);
		logic [7:0] got;
		logic got_valid;
		io_read(port, got, got_valid);
		check_value("data_valid_o", 32'(got_valid), 32'(1));
		check_value("data_o", 32'(got), 32'(expected));
	endtask

	task automatic read_expect_idle(input logic [15:0] port);
		logic [7:0] got;
		logic got_valid;
		io_read(port, got, got_valid);
		check_value("data_valid_o", 32'(got_valid), 32'(0));
		check_value("data_o", 32'(got), 32'(0));
	endtask

	task automatic mem_access(input logic [19:0] addr);
		@(posedge clock);
		address <= addr;
		address_enable_n <= 1'b0;
		memory_read_n <= 1'b0;
		@(negedge clock);
		check_value("sram_addr_o", 32'(sram_addr), 32'(expected_sram(addr, ems_window)));
		@(posedge clock);
		address_enable_n <= 1'b1;
		memory_read_n <= 1'b1;
	endtask

	task automatic drive_peripheral_clock();
		logic [31:0] hold;
		while (peripheral_running) begin
			hold = $urandom_range(6, 2);
			repeat (hold) @(posedge clock);
			if (!peripheral_clock)
				rises++;
			peripheral_clock <= !peripheral_clock;
		end
	endtask

	always @(negedge clock) begin
		if (timer_clock != timer_prev)
			toggles++;
		timer_prev = timer_clock;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before all transactions completed");
		$display("Verification failed");
		$fatal(1, "simulation timed out");
	end

	initial begin
		logic [31:0] r;
		logic [7:0] value;
		logic [1:0] idx;
		void'($urandom(77775));
		address <= '0;
		data_in <= '0;
		io_read_n <= 1'b1;
		io_write_n <= 1'b1;
		memory_read_n <= 1'b1;
		address_enable_n <= 1'b1;
		ems_enabled <= 1'b1;
		ems_window <= 2'd0;
		peripheral_clock <= 1'b0;
		peripheral_running = 1'b1;
		for (int i = 0; i < `EMS_PAGE_COUNT; i++)
			model_page[i] = '0;
		model_en = '0;
		model_lpt = `LPT_RESET_VALUE;
		model_xtctl = `XTCTL_RESET_VALUE;
		wait (!reset);
		@(negedge clock);
		check_value("data_valid_o", 32'(data_valid), 32'(0));
		check_value("data_o", 32'(data_out), 32'(0));
		check_value("xtctl_o", 32'(xtctl), 32'(model_xtctl));
		check_value("timer_clock_o", 32'(timer_clock), 32'(0));
		for (int i = 0; i < RESET_ACCESSES; i++) begin
			r = $urandom();
			mem_access(r[19:0]);
		end
		fork
			drive_peripheral_clock();
		join_none

		for (int i = 0; i < EMS_WRITES; i++) begin
			r = $urandom();
			idx = r[1:0];
			value = random_ems_data();
			io_write(ems_port(idx), value);
			model_write(idx, value);
			read_and_check(ems_port(idx), ems_expected(idx));
		end

		for (int w = 0; w < 4; w++) begin
			@(posedge clock);
			ems_window <= 2'(w);
			for (int p = 0; p < `EMS_PAGE_COUNT; p++) begin
				value = random_ems_data();
				io_write(ems_port(2'(p)), value);
				model_write(2'(p), value);
			end
			for (int i = 0; i < TRANSLATIONS; i++) begin
				r = $urandom();
				// half the accesses land inside the frame
				if (r[31])
					r[19:16] = frame_nibble(2'(w));
				mem_access(r[19:0]);
			end
		end

		for (int i = 0; i < PORT_ROUNDS; i++) begin
			r = $urandom();
			io_write(`LPT_PORT, r[7:0]);
			model_lpt = r[7:0];
			io_write(`XTCTL_PORT, r[15:8]);
			model_xtctl = r[15:8];
			read_and_check(`LPT_PORT, model_lpt);
			read_and_check(`XTCTL_PORT, model_xtctl);
			check_value("xtctl_o", 32'(xtctl), 32'(model_xtctl));
			// ports 0400..07FF decode to nothing
			read_expect_idle({6'h01, r[25:16]});
		end

		@(posedge clock);
		ems_enabled <= 1'b0;
		for (int i = 0; i < DISABLED_WRITES; i++) begin
			r = $urandom();
			idx = r[1:0];
			io_write(ems_port(idx), random_ems_data());
			read_expect_idle(ems_port(idx));
		end
		@(posedge clock);
		ems_enabled <= 1'b1;
		for (int p = 0; p < `EMS_PAGE_COUNT; p++)
			read_and_check(ems_port(2'(p)), ems_expected(2'(p)));

		// stop the peripheral clock and let its last edge clear the synchronizer
		peripheral_running = 1'b0;
		repeat (20) @(posedge clock);
		@(negedge clock);
		check_value("timer_clock_o toggles", 32'(toggles), 32'(rises));

		if (error_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Verification failed");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clock_o,
	output logic reset_o
);

	// 8 ns period
	initial begin
		clock_o = 1'b0;
		forever #4 clock_o = !clock_o;
	end

	initial begin
		reset_o <= 1'b1;
		repeat (8) @(posedge clock_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire
